/* run.sh */
#!/usr/bin/env bash
# Build and run the SD command path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_sd_cmd -Mdir obj_dir
./obj_dir/Vtb_sd_cmd | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

/* sd_cfg.svh */
`ifndef SD_CFG_SVH
`define SD_CFG_SVH

// Command token fields
`define SD_CMD_IDX_W 6
`define SD_CMD_ARG_W 32
`define SD_CRC_W     7

// Command and 48-bit response tokens share one length
`define SD_TOKEN_W   48

// Cycles after the command end bit before a missing response is a timeout
`define SD_NCR_MAX   64

// Complete, timeout, CRC, end bit, index
`define SD_INT_W     5

`endif

/* sd_cmd_check.sv */
`default_nettype none
`include "sd_cfg.svh"

module sd_cmd_check (
    input  wire                      sd_clk_i,
    input  wire                      rst_i,
    sd_resp_if.check                 resp,
    input  wire sd_pkg::int_status_t int_en_i,
    input  wire sd_pkg::int_status_t int_clr_i,
    output logic                     done_o,
    output sd_pkg::cmd_arg_t         resp_arg_o,
    output sd_pkg::int_status_t      int_status_o,
    output logic                     irq_o
);
    import sd_pkg::*;

    // Status bit positions
    localparam int INT_CC   = 0;
    localparam int INT_CTO  = 1;
    localparam int INT_CCRC = 2;
    localparam int INT_CEND = 3;
    localparam int INT_CIDX = 4;

    // Response token field positions
    localparam int IDX_LSB = `SD_TOKEN_W - 2 - `SD_CMD_IDX_W;
    localparam int ARG_LSB = IDX_LSB - `SD_CMD_ARG_W;

    int_status_t set_mask;
    logic        resp_ok;
    crc7_t       crc_rx;
    cmd_idx_t    idx_rx;

    assign crc_rx  = resp.token[ARG_LSB-1:1];
    assign idx_rx  = resp.token[IDX_LSB+`SD_CMD_IDX_W-1:IDX_LSB];
    assign resp_ok = resp.valid & (resp.kind == RESP_48) & ~resp.timed_out;

    always_comb begin
        set_mask         = '0;
        set_mask[INT_CC] = resp.valid;
        if (resp.valid && resp.kind == RESP_48 && resp.timed_out) begin
            set_mask[INT_CTO] = 1'b1;
        end
        if (resp_ok) begin
            set_mask[INT_CCRC] = (crc_rx != sd_crc7(resp.token));
            set_mask[INT_CEND] = ~resp.token[0];
            set_mask[INT_CIDX] = (idx_rx != resp.idx);
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (rst_i) begin
            int_status_o <= '0;
            done_o       <= 1'b0;
        end else begin
            // New events take priority over a clear
            int_status_o <= (int_status_o & ~int_clr_i) | set_mask;
            done_o       <= resp.valid;
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (resp_ok) begin
            resp_arg_o <= resp.token[ARG_LSB+`SD_CMD_ARG_W-1:ARG_LSB];
        end
    end

    assign irq_o = |(int_status_o & int_en_i);

endmodule

`default_nettype wire

/* sd_cmd_ctrl.sv */
`default_nettype none

module sd_cmd_ctrl (
    input  wire                      sd_clk_i,
    input  wire                      rst_i,
    input  wire                      start_i,
    input  wire sd_pkg::cmd_idx_t    cmd_idx_i,
    input  wire sd_pkg::cmd_arg_t    cmd_arg_i,
    input  wire sd_pkg::resp_kind_t  resp_kind_i,
    output wire                      busy_o,
    input  wire                      sd_cmd_i,
    output wire                      sd_cmd_o,
    output wire                      sd_cmd_oe_o,
    output wire                      done_o,
    output wire sd_pkg::cmd_arg_t    resp_arg_o,
    output wire sd_pkg::int_status_t int_status_o,
    input  wire sd_pkg::int_status_t int_en_i,
    input  wire sd_pkg::int_status_t int_clr_i,
    output wire                      irq_o
);

    sd_cmd_if  cmd_if ();
    sd_resp_if resp_if ();

    sd_cmd_frame i_sd_cmd_frame (
        .sd_clk_i    (sd_clk_i),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .cmd_idx_i   (cmd_idx_i),
        .cmd_arg_i   (cmd_arg_i),
        .resp_kind_i (resp_kind_i),
        .busy_o      (busy_o),
        .cmd         (cmd_if.frame)
    );

    // CMD line driver and response capture
    sd_cmd_serial i_sd_cmd_serial (
        .sd_clk_i    (sd_clk_i),
        .rst_i       (rst_i),
        .cmd         (cmd_if.line),
        .resp        (resp_if.line),
        .sd_cmd_i    (sd_cmd_i),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

    sd_cmd_check i_sd_cmd_check (
        .sd_clk_i     (sd_clk_i),
        .rst_i        (rst_i),
        .resp         (resp_if.check),
        .int_en_i     (int_en_i),
        .int_clr_i    (int_clr_i),
        .done_o       (done_o),
        .resp_arg_o   (resp_arg_o),
        .int_status_o (int_status_o),
        .irq_o        (irq_o)
    );

endmodule

`default_nettype wire

/* sd_cmd_frame.sv */
`default_nettype none
`include "sd_cfg.svh"

module sd_cmd_frame (
    input  wire                     sd_clk_i,
    input  wire                     rst_i,
    input  wire                     start_i,
    input  wire sd_pkg::cmd_idx_t   cmd_idx_i,
    input  wire sd_pkg::cmd_arg_t   cmd_arg_i,
    input  wire sd_pkg::resp_kind_t resp_kind_i,
    output logic                    busy_o,
    sd_cmd_if.frame                 cmd
);
    import sd_pkg::*;

    logic      pending;
    logic      accept;
    sd_token_t body;
    sd_token_t token_next;

    assign busy_o = pending | cmd.busy;
    assign accept = start_i & ~busy_o;

    // Header fields with CRC and end bit zeroed
    assign body       = {1'b0, 1'b1, cmd_idx_i, cmd_arg_i, {(`SD_CRC_W + 1){1'b0}}};
    assign token_next = {body[`SD_TOKEN_W-1:`SD_CRC_W+1], sd_crc7(body), 1'b1};

    assign cmd.valid = pending;

    always_ff @(posedge sd_clk_i) begin
        if (rst_i) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (accept) begin
            cmd.token <= token_next;
            cmd.kind  <= resp_kind_i;
            cmd.idx   <= cmd_idx_i;
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_ifs.sv */
`default_nettype none

// Frame build to serial line
interface sd_cmd_if;
    import sd_pkg::*;

    logic       valid;
    sd_token_t  token;
    resp_kind_t kind;
    cmd_idx_t   idx;
    logic       busy;

    modport frame (output valid, token, kind, idx, input busy);
    modport line  (input valid, token, kind, idx, output busy);
endinterface

// Serial line to response check
interface sd_resp_if;
    import sd_pkg::*;

    logic       valid;
    sd_token_t  token;
    resp_kind_t kind;
    cmd_idx_t   idx;
    logic       timed_out;

    modport line  (output valid, token, kind, idx, timed_out);
    modport check (input valid, token, kind, idx, timed_out);
endinterface

`default_nettype wire

/* sd_cmd_serial.sv */
`default_nettype none
`include "sd_cfg.svh"

module sd_cmd_serial (
    input  wire     sd_clk_i,
    input  wire     rst_i,
    sd_cmd_if.line  cmd,
    sd_resp_if.line resp,
    input  wire     sd_cmd_i,
    output logic    sd_cmd_o,
    output logic    sd_cmd_oe_o
);
    import sd_pkg::*;

    localparam int CNT_W = $clog2(`SD_NCR_MAX + `SD_TOKEN_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SD_TOKEN_W - 1);
    localparam logic [CNT_W-1:0] NCR_LAST = CNT_W'(`SD_NCR_MAX - 1);

    line_state_t      state;
    sd_token_t        shreg;
    logic [CNT_W-1:0] bit_cnt;
    resp_kind_t       kind_q;
    cmd_idx_t         idx_q;

    assign cmd.busy   = (state != IDLE);
    assign resp.token = shreg;
    assign resp.kind  = kind_q;
    assign resp.idx   = idx_q;

    always_ff @(posedge sd_clk_i) begin
        if (rst_i) begin
            state          <= IDLE;
            bit_cnt        <= '0;
            sd_cmd_o       <= 1'b1;
            sd_cmd_oe_o    <= 1'b0;
            resp.valid     <= 1'b0;
            resp.timed_out <= 1'b0;
        end else begin
            resp.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd.valid) begin
                        state       <= SEND;
                        bit_cnt     <= '0;
                        sd_cmd_oe_o <= 1'b1;
                        sd_cmd_o    <= cmd.token[`SD_TOKEN_W-1];
                    end
                end
                SEND: begin
                    if (bit_cnt == LAST_BIT) begin
                        // End bit done, release the line
                        sd_cmd_oe_o <= 1'b0;
                        sd_cmd_o    <= 1'b1;
                        bit_cnt     <= '0;
                        if (kind_q == RESP_48) begin
                            state <= WAIT;
                        end else begin
                            state          <= IDLE;
                            resp.valid     <= 1'b1;
                            resp.timed_out <= 1'b0;
                        end
                    end else begin
                        sd_cmd_o <= shreg[`SD_TOKEN_W-1];
                        bit_cnt  <= bit_cnt + 1'b1;
                    end
                end
                WAIT: begin
                    if (!sd_cmd_i) begin
                        // Start bit already captured
                        state   <= RECV;
                        bit_cnt <= CNT_W'(1);
                    end else if (bit_cnt == NCR_LAST) begin
                        state          <= IDLE;
                        resp.valid     <= 1'b1;
                        resp.timed_out <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RECV: begin
                    if (bit_cnt == LAST_BIT) begin
                        state          <= IDLE;
                        resp.valid     <= 1'b1;
                        resp.timed_out <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Shift register serves both directions
    always_ff @(posedge sd_clk_i) begin
        case (state)
            IDLE: begin
                if (cmd.valid) begin
                    shreg  <= {cmd.token[`SD_TOKEN_W-2:0], 1'b0};
                    kind_q <= cmd.kind;
                    idx_q  <= cmd.idx;
                end
            end
            SEND: begin
                shreg <= {shreg[`SD_TOKEN_W-2:0], 1'b0};
            end
            WAIT: begin
                if (!sd_cmd_i) begin
                    shreg <= {shreg[`SD_TOKEN_W-2:0], sd_cmd_i};
                end
            end
            default: begin
                shreg <= {shreg[`SD_TOKEN_W-2:0], sd_cmd_i};
            end
        endcase
    end

endmodule

`default_nettype wire

/* sd_pkg.sv */
`default_nettype none
`include "sd_cfg.svh"

package sd_pkg;

    typedef logic [`SD_CMD_IDX_W-1:0] cmd_idx_t;
    typedef logic [`SD_CMD_ARG_W-1:0] cmd_arg_t;
    typedef logic [`SD_TOKEN_W-1:0]   sd_token_t;
    typedef logic [`SD_CRC_W-1:0]     crc7_t;
    typedef logic [`SD_INT_W-1:0]     int_status_t;

    typedef enum logic {
        RESP_NONE,
        RESP_48
    } resp_kind_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT,
        RECV
    } line_state_t;

    // CRC7 over the leading 40 bits, MSB first, x^7 + x^3 + 1
    function automatic crc7_t sd_crc7(input sd_token_t token);
        crc7_t crc;
        logic  fb;
        crc = '0;
        for (int i = `SD_TOKEN_W - 1; i > `SD_CRC_W; i--) begin
            fb  = token[i] ^ crc[`SD_CRC_W-1];
            crc = {crc[`SD_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ crc7_t'(7'h09);
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

/* sim.f */
+incdir+.
sd_pkg.sv
sd_cmd_ifs.sv
sd_cmd_frame.sv
sd_cmd_serial.sv
sd_cmd_check.sv
sd_cmd_ctrl.sv
tb_sd_cmd.sv

/* tb_sd_cmd.sv */
`default_nettype none
`include "sd_cfg.svh"

module tb_sd_cmd;
    import sd_pkg::*;

    typedef logic [63:0] val_t;

    localparam int N_TESTS     = 10;
    localparam int TEST_CYC    = 2 + `SD_TOKEN_W + `SD_NCR_MAX + `SD_TOKEN_W + 10;
    localparam int MODE_OK     = 0;
    localparam int MODE_CRC    = 1;
    localparam int MODE_IDX    = 2;
    localparam int MODE_END    = 3;
    localparam int MODE_SILENT = 4;

    logic        sd_clk_i;
    logic        rst_i;
    logic        start_i;
    cmd_idx_t    cmd_idx_i;
    cmd_arg_t    cmd_arg_i;
    resp_kind_t  resp_kind_i;
    logic        busy_o;
    logic        sd_cmd_i;
    logic        sd_cmd_o;
    logic        sd_cmd_oe_o;
    logic        done_o;
    cmd_arg_t    resp_arg_o;
    int_status_t int_status_o;
    int_status_t int_en_i;
    int_status_t int_clr_i;
    logic        irq_o;

    // Card model setup for the next response
    resp_kind_t  card_kind;
    logic        card_silent;
    int          card_delay;
    sd_token_t   card_resp;
    sd_token_t   cap_token;
    int          cap_len;
    int          tokens_seen;

    sd_token_t   exp_token_q[$];
    int_status_t exp_status_q[$];
    cmd_arg_t    exp_arg_q[$];
    logic        exp_has_arg_q[$];

    logic [15:0] lfsr = 16'd68;
    int issued;
    int checked;
    int done_count;
    int stim_errors;
    int chk_errors;
    int n_tests;
    int failed_tests;
    int errs_at_open;

    sd_cmd_ctrl i_sd_cmd_ctrl (
        .sd_clk_i     (sd_clk_i),
        .rst_i        (rst_i),
        .start_i      (start_i),
        .cmd_idx_i    (cmd_idx_i),
        .cmd_arg_i    (cmd_arg_i),
        .resp_kind_i  (resp_kind_i),
        .busy_o       (busy_o),
        .sd_cmd_i     (sd_cmd_i),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe_o  (sd_cmd_oe_o),
        .done_o       (done_o),
        .resp_arg_o   (resp_arg_o),
        .int_status_o (int_status_o),
        .int_en_i     (int_en_i),
        .int_clr_i    (int_clr_i),
        .irq_o        (irq_o)
    );

    initial begin
        sd_clk_i = 1'b0;
        forever #2 sd_clk_i = ~sd_clk_i;
    end

    // Galois LFSR with taps 16 14 13 11
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Remainder of M(x) * x^7 divided by x^7 + x^3 + 1
    function automatic crc7_t ref_crc7(input sd_token_t t);
        logic [46:0] rem;
        rem = {t[47:8], 7'd0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'h89;
            end
        end
        return rem[6:0];
    endfunction

    function automatic sd_token_t build_token(input logic trans, input cmd_idx_t idx,
                                              input cmd_arg_t arg);
        sd_token_t t;
        t      = {1'b0, trans, idx, arg, 7'd0, 1'b1};
        t[7:1] = ref_crc7(t);
        return t;
    endfunction

    function automatic sd_token_t build_resp(input cmd_idx_t idx, input cmd_arg_t arg,
                                             input int mode, input int crc_bit);
        sd_token_t t;
        cmd_idx_t  echo;
        echo = (mode == MODE_IDX) ? idx + 6'd1 : idx;
        t    = build_token(1'b0, echo, arg);
        if (mode == MODE_CRC) begin
            t[1 + crc_bit] = ~t[1 + crc_bit];
        end
        if (mode == MODE_END) begin
            t[0] = 1'b0;
        end
        return t;
    endfunction

    // Complete bit plus one fault bit for RESP_48
    function automatic int_status_t expect_status(input resp_kind_t kind, input int mode);
        int_status_t s;
        s = 5'b00001;
        if (kind == RESP_48) begin
            case (mode)
                MODE_SILENT: s[1] = 1'b1;
                MODE_CRC:    s[2] = 1'b1;
                MODE_END:    s[3] = 1'b1;
                MODE_IDX:    s[4] = 1'b1;
                default:     s = 5'b00001;
            endcase
        end
        return s;
    endfunction

    function automatic bit check_value(input string name, input val_t got, input val_t exp);
        bit ok;
        ok = 1'b1;
        assert (got == exp) else begin
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
            ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic run_cmd(input cmd_idx_t idx, input resp_kind_t kind, input int mode);
        cmd_arg_t arg;
        cmd_arg_t card_val;
        int       crc_bit;
        arg         = cmd_arg_t'(rand_bits(32));
        card_val    = cmd_arg_t'(rand_bits(32));
        crc_bit     = int'(rand_bits(3)) % `SD_CRC_W;
        card_delay  = 1 + int'(rand_bits(5));
        card_kind   = kind;
        card_silent = (mode == MODE_SILENT);
        card_resp   = build_resp(idx, card_val, mode, crc_bit);
        exp_token_q.push_back(build_token(1'b1, idx, arg));
        exp_status_q.push_back(expect_status(kind, mode));
        exp_arg_q.push_back(card_val);
        exp_has_arg_q.push_back(kind == RESP_48 && mode != MODE_SILENT);
        issued++;
        cmd_idx_i   = idx;
        cmd_arg_i   = arg;
        resp_kind_i = kind;
        start_i     = 1'b1;
        @(posedge sd_clk_i);
        #1;
        start_i = 1'b0;
    endtask

    task automatic wait_checked();
        while (checked != issued) begin
            @(posedge sd_clk_i);
            #1;
        end
    endtask

    task automatic clear_status(input int_status_t mask);
        int_clr_i = mask;
        @(posedge sd_clk_i);
        #1;
        int_clr_i = '0;
    endtask

    task automatic close_test(input string name);
        int errs_now;
        errs_now = stim_errors + chk_errors;
        n_tests++;
        if (errs_now != errs_at_open) begin
            failed_tests++;
            $display("test %0d %s: error", n_tests, name);
        end else begin
            $display("test %0d %s: ok", n_tests, name);
        end
        errs_at_open = errs_now;
    endtask

    // Card captures the command and answers after a random gap
    initial begin
        sd_token_t shift;
        int        len;
        sd_cmd_i    = 1'b1;
        tokens_seen = 0;
        cap_len     = 0;
        cap_token   = '0;
        shift       = '0;
        len         = 0;
        forever begin
            @(negedge sd_clk_i);
            if (sd_cmd_oe_o) begin
                shift = {shift[`SD_TOKEN_W-2:0], sd_cmd_o};
                len++;
            end else if (len != 0) begin
                cap_token = shift;
                cap_len   = len;
                len       = 0;
                tokens_seen++;
                if (card_kind == RESP_48 && !card_silent) begin
                    repeat (card_delay) @(posedge sd_clk_i);
                    for (int i = `SD_TOKEN_W - 1; i >= 0; i--) begin
                        #1;
                        sd_cmd_i = card_resp[i];
                        @(posedge sd_clk_i);
                    end
                    #1;
                    sd_cmd_i = 1'b1;
                end
            end
        end
    end

    // Compare each completed command with the reference
    initial begin
        sd_token_t   tok;
        int_status_t st;
        cmd_arg_t    arg;
        logic        has_arg;
        chk_errors = 0;
        checked    = 0;
        done_count = 0;
        forever begin
            @(negedge sd_clk_i);
            if (done_o) begin
                done_count++;
                if (exp_status_q.size() == 0) begin
                    $display("Unexpected done_o at time %0t with no command pending", $time);
                    chk_errors++;
                end else begin
                    tok     = exp_token_q.pop_front();
                    st      = exp_status_q.pop_front();
                    arg     = exp_arg_q.pop_front();
                    has_arg = exp_has_arg_q.pop_front();
                    if (!check_value("sd_cmd_oe_o cycles", val_t'(cap_len), val_t'(`SD_TOKEN_W)))
                        chk_errors++;
                    if (!check_value("sd_cmd_o token", val_t'(cap_token), val_t'(tok)))
                        chk_errors++;
                    if (!check_value("int_status_o", val_t'(int_status_o), val_t'(st)))
                        chk_errors++;
                    if (!check_value("irq_o", val_t'(irq_o), val_t'(|(st & int_en_i))))
                        chk_errors++;
                    if (has_arg && !check_value("resp_arg_o", val_t'(resp_arg_o), val_t'(arg)))
                        chk_errors++;
                    checked++;
                end
            end
        end
    end

    initial begin
        int_status_t st;
        int          tok_before;
        int          done_before;
        rst_i        = 1'b1;
        start_i      = 1'b0;
        cmd_idx_i    = '0;
        cmd_arg_i    = '0;
        resp_kind_i  = RESP_NONE;
        int_en_i     = '1;
        int_clr_i    = '0;
        card_kind    = RESP_NONE;
        card_silent  = 1'b0;
        card_delay   = 1;
        card_resp    = '1;
        issued       = 0;
        stim_errors  = 0;
        n_tests      = 0;
        failed_tests = 0;
        errs_at_open = 0;
        repeat (2) @(posedge sd_clk_i);
        #1;
        rst_i = 1'b0;
        if (!check_value("reset outputs", val_t'({busy_o, done_o, sd_cmd_oe_o, irq_o,
                         int_status_o, sd_cmd_o}), val_t'(10'b0000_00000_1)))
            stim_errors++;

        run_cmd(cmd_idx_t'(rand_bits(6)), RESP_NONE, MODE_OK);
        wait_checked();
        clear_status('1);
        if (!check_value("int_status_o", val_t'(int_status_o), 0)) stim_errors++;
        close_test("no response");

        for (int k = 0; k < 4; k++) begin
            run_cmd(cmd_idx_t'(rand_bits(6)), RESP_48, MODE_OK);
            wait_checked();
            clear_status('1);
            close_test("good response");
        end

        for (int m = MODE_CRC; m <= MODE_END; m++) begin
            run_cmd(cmd_idx_t'(rand_bits(6)), RESP_48, m);
            wait_checked();
            clear_status('1);
            close_test("injected fault");
        end

        // Silent card followed by irq masking and single-bit clears
        run_cmd(cmd_idx_t'(rand_bits(6)), RESP_48, MODE_SILENT);
        wait_checked();
        st = expect_status(RESP_48, MODE_SILENT);
        for (int k = 0; k < 8; k++) begin
            int_en_i = int_status_t'(rand_bits(5));
            @(posedge sd_clk_i);
            #1;
            if (!check_value("irq_o", val_t'(irq_o), val_t'(|(st & int_en_i)))) stim_errors++;
        end
        int_en_i = 5'b00001;
        clear_status(5'b00001);
        if (!check_value("int_status_o", val_t'(int_status_o), val_t'(st & 5'b11110)))
            stim_errors++;
        if (!check_value("irq_o", val_t'(irq_o), 0)) stim_errors++;
        int_en_i = 5'b00010;
        @(posedge sd_clk_i);
        #1;
        if (!check_value("irq_o", val_t'(irq_o), 1)) stim_errors++;
        clear_status(5'b00010);
        if (!check_value("int_status_o", val_t'(int_status_o), 0)) stim_errors++;
        if (!check_value("irq_o", val_t'(irq_o), 0)) stim_errors++;
        int_en_i = '1;
        close_test("timeout and irq");

        tok_before  = tokens_seen;
        done_before = done_count;
        run_cmd(cmd_idx_t'(rand_bits(6)), RESP_48, MODE_OK);
        repeat (4) @(posedge sd_clk_i);
        #1;
        if (!check_value("busy_o", val_t'(busy_o), 1)) stim_errors++;
        cmd_idx_i = cmd_idx_i + 6'd1;
        start_i   = 1'b1;
        @(posedge sd_clk_i);
        #1;
        start_i = 1'b0;
        wait_checked();
        // Long enough for a second token to show up on the line
        repeat (`SD_TOKEN_W + 10) @(posedge sd_clk_i);
        #1;
        if (!check_value("tokens on line", val_t'(tokens_seen), val_t'(tok_before + 1)))
            stim_errors++;
        if (!check_value("done_o pulses", val_t'(done_count), val_t'(done_before + 1)))
            stim_errors++;
        clear_status('1);
        close_test("start while busy");

        $display("Summary: %0d tests, %0d failed tests, %0d failed checks", n_tests,
                 failed_tests, stim_errors + chk_errors);
        if (failed_tests == 0 && stim_errors + chk_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (N_TESTS * TEST_CYC) @(posedge sd_clk_i);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 N_TESTS * TEST_CYC);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
